// ==== src/lsu_settings.svh ====
// load/store unit settings
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ********************
// datapath
// ********************

// data and address width in bits.
`define LSU_XLEN 32

// ********************
// data memory
// ********************

// depth in words, the word index wraps at this size.
`define LSU_MEM_WORDS 256

// stall cycles before each access is taken, zero allowed.
`define LSU_WAIT_STATES 2

`endif

// ==== src/lsu_pkg.sv ====
// load/store unit types
`include "lsu_settings.svh"

package lsu_pkg;

    // ********************
    // operations
    // ********************

    typedef enum logic [2:0] {
        MEM_LB  = 3'd0,
        MEM_LH  = 3'd1,
        MEM_LW  = 3'd2,
        MEM_LBU = 3'd3,
        MEM_LHU = 3'd4,
        MEM_SB  = 3'd5,
        MEM_SH  = 3'd6,
        MEM_SW  = 3'd7
    } mem_op_e;

    // ********************
    // request and bus
    // ********************

    // request as seen from the core.
    typedef struct packed {
        mem_op_e              op;
        logic [`LSU_XLEN-1:0] addr;   // byte address.
        logic [`LSU_XLEN-1:0] wdata;
    } lsu_req_t;

    // one word access toward the memory.
    typedef struct packed {
        logic                 sel;
        logic                 we;
        logic [`LSU_XLEN-3:0] word_addr;
        logic [`LSU_XLEN-1:0] wdata;    // already on its lanes.
        logic [3:0]           mask;
    } bus_req_t;

    // what the load result path needs one cycle later.
    typedef struct packed {
        mem_op_e    op;
        logic [1:0] offset;
    } load_ctx_t;

    function automatic logic is_store(input mem_op_e op);
        return (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
    endfunction

endpackage

// ==== src/lsu_ctrl.sv ====
// load/store control
module lsu_ctrl (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  logic               hold_i,
    input  lsu_pkg::mem_op_e   op_i,
    input  logic [1:0]         offset_i,
    input  logic               mem_stall_i,
    output logic               bus_sel_o,
    output logic               bus_we_o,
    output logic               done_o,
    output logic               load_valid_o,
    output lsu_pkg::load_ctx_t ctx_o
);
    import lsu_pkg::*;

    logic      accept;
    logic      store_op;
    logic      load_valid_q;
    load_ctx_t ctx_q;

    // ********************
    // bus side
    // ********************

    assign store_op  = is_store(op_i);
    assign bus_sel_o = start_i && !hold_i;   // downstream stall blocks the bus.
    assign bus_we_o  = bus_sel_o && store_op;

    // memory takes the access in this cycle.
    assign accept = start_i && !hold_i && !mem_stall_i;

    // idle core sees done, busy core waits for acceptance.
    assign done_o = start_i ? accept : 1'b1;

    // ********************
    // load result context
    // ********************

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_valid_q <= 1'b0;
        end else begin
            load_valid_q <= accept && !store_op;
        end
    end

    // payload only, qualified by load_valid_o.
    always_ff @(posedge clk_i) begin
        if (accept && !store_op) begin
            ctx_q.op     <= op_i;
            ctx_q.offset <= offset_i;
        end
    end

    assign load_valid_o = load_valid_q;
    assign ctx_o        = ctx_q;

endmodule

// ==== src/store_align.sv ====
// store lane alignment
`include "lsu_settings.svh"

module store_align (
    input  lsu_pkg::lsu_req_t     req_i,
    output logic [`LSU_XLEN-3:0]  addr_o,
    output logic [3:0]            mask_o,
    output logic [`LSU_XLEN-1:0]  wdata_o
);
    import lsu_pkg::*;

    logic [1:0] offset;

    assign offset = req_i.addr[1:0];
    assign addr_o = req_i.addr[`LSU_XLEN-1:2];   // low bits dropped.

    always_comb begin
        case (req_i.op)
            MEM_SB: begin
                mask_o  = 4'b0001 << offset;
                wdata_o = {4{req_i.wdata[7:0]}};
            end
            MEM_SH: begin
                // bit 0 ignored for halves.
                mask_o  = offset[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{req_i.wdata[15:0]}};
            end
            MEM_SW: begin
                mask_o  = 4'b1111;
                wdata_o = req_i.wdata;
            end
            default: begin
                mask_o  = 4'b1111;   // loads, we is low.
                wdata_o = req_i.wdata;
            end
        endcase
    end

endmodule

// ==== src/load_extract.sv ====
// load lane extraction
`include "lsu_settings.svh"

module load_extract (
    input  lsu_pkg::load_ctx_t    ctx_i,
    input  logic [`LSU_XLEN-1:0]  rdata_i,
    output logic [`LSU_XLEN-1:0]  result_o
);
    import lsu_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // ********************
    // lane select
    // ********************

    always_comb begin
        byte_lane = rdata_i[8*ctx_i.offset +: 8];
        half_lane = ctx_i.offset[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    // ********************
    // extension
    // ********************

    always_comb begin
        case (ctx_i.op)
            MEM_LB: begin
                result_o = {{24{byte_lane[7]}}, byte_lane};
            end
            MEM_LBU: begin
                result_o = {24'h000000, byte_lane};
            end
            MEM_LH: begin
                result_o = {{16{half_lane[15]}}, half_lane};
            end
            MEM_LHU: begin
                result_o = {16'h0000, half_lane};
            end
            default: begin
                result_o = rdata_i;   // LW.
            end
        endcase
    end

endmodule

// ==== src/data_ram.sv ====
// local data memory
`include "lsu_settings.svh"

module data_ram (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  lsu_pkg::bus_req_t     bus_i,
    output logic                  stall_o,
    output logic [`LSU_XLEN-1:0]  rdata_o
);
    localparam int unsigned WAIT  = `LSU_WAIT_STATES;
    localparam int unsigned DEPTH = `LSU_MEM_WORDS;
    localparam int unsigned IDX_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

    logic [`LSU_XLEN-1:0] mem_q [DEPTH];
    logic [`LSU_XLEN-1:0] rdata_q;
    logic [CNT_W-1:0]     wait_cnt_q;
    logic [IDX_W-1:0]     idx;
    logic                 accept;

    // wraps modulo the depth.
    assign idx = bus_i.word_addr[IDX_W-1:0];

    // ********************
    // wait states
    // ********************

    assign stall_o = bus_i.sel && (wait_cnt_q != CNT_W'(WAIT));
    assign accept  = bus_i.sel && !stall_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wait_cnt_q <= '0;
        end else if (stall_o) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end else begin
            wait_cnt_q <= '0;   // on acceptance or idle bus.
        end
    end

    // ********************
    // storage
    // ********************

    always_ff @(posedge clk_i) begin
        if (accept) begin
            if (bus_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_i.mask[b]) begin
                        mem_q[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== src/lsu_top.sv ====
// load/store unit top
`include "lsu_settings.svh"

module lsu_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  hold_i,
    input  lsu_pkg::lsu_req_t     req_i,
    output logic                  done_o,
    output logic                  load_valid_o,
    output logic [`LSU_XLEN-1:0]  result_o
);
    import lsu_pkg::*;

    logic                 bus_sel;
    logic                 bus_we;
    logic [`LSU_XLEN-3:0] word_addr;
    logic [3:0]           mask;
    logic [`LSU_XLEN-1:0] wdata;
    logic                 mem_stall;
    logic [`LSU_XLEN-1:0] rdata;
    load_ctx_t            ctx;
    bus_req_t             bus;

    lsu_ctrl ctrl_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .hold_i       (hold_i),
        .op_i         (req_i.op),
        .offset_i     (req_i.addr[1:0]),
        .mem_stall_i  (mem_stall),
        .bus_sel_o    (bus_sel),
        .bus_we_o     (bus_we),
        .done_o       (done_o),
        .load_valid_o (load_valid_o),
        .ctx_o        (ctx)
    );

    store_align store_align_i (
        .req_i   (req_i),
        .addr_o  (word_addr),
        .mask_o  (mask),
        .wdata_o (wdata)
    );

    // control strobes merged with the aligned payload.
    assign bus.sel       = bus_sel;
    assign bus.we        = bus_we;
    assign bus.word_addr = word_addr;
    assign bus.wdata     = wdata;
    assign bus.mask      = mask;

    data_ram ram_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (bus),
        .stall_o (mem_stall),
        .rdata_o (rdata)
    );

    load_extract load_extract_i (
        .ctx_i    (ctx),
        .rdata_i  (rdata),
        .result_o (result_o)
    );

endmodule

// ==== testbench/lsu_checker.sv ====
// load/store result checker
`include "lsu_settings.svh"

module lsu_checker (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic                 hold_i,
    input  lsu_pkg::lsu_req_t    req_i,
    input  logic                 done_i,
    input  logic                 load_valid_i,
    input  logic [`LSU_XLEN-1:0] result_i,
    input  int                   test_id_i,
    output int                   data_errs_o,
    output int                   proto_errs_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int DEPTH = `LSU_MEM_WORDS;
    localparam int WAIT  = `LSU_WAIT_STATES;
    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0] shadow [DEPTH];
    logic        pending;
    logic [31:0] expected;
    logic [31:0] pending_addr;
    int          pending_test;
    int          busy_cnt;
    int          data_errs = 0;
    int          proto_errs = 0;

    function automatic string test_name(input int id);
        case (id)
            0: return "fill";
            1: return "word_round_trip";
            2: return "byte_half_merge";
            3: return "extension";
            4: return "hold";
            5: return "back_to_back";
            6: return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
        return IDX_W'(addr >> 2);   // wraps at the depth.
    endfunction

    // ********************
    // reference model
    // ********************

    function automatic logic [31:0] ref_load(input logic [31:0] word, input mem_op_e op,
                                             input logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * int'(addr[1:0])));
        h = 16'(word >> (addr[1] ? 16 : 0));   // bit 0 ignored.
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] word, input mem_op_e op,
                                                input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] keep;
        logic [31:0] bits;
        int          sh;
        sh = (op == MEM_SB) ? 8 * int'(addr[1:0]) : (addr[1] ? 16 : 0);
        case (op)
            MEM_SB: begin
                keep = ~(32'h0000_00ff << sh);
                bits = {24'd0, data[7:0]} << sh;
            end
            MEM_SH: begin
                keep = ~(32'h0000_ffff << sh);
                bits = {16'd0, data[15:0]} << sh;
            end
            default: begin
                keep = '0;
                bits = data;
            end
        endcase
        return (word & keep) | bits;
    endfunction

    // ********************
    // comparing process
    // ********************

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            pending  = 1'b0;
            busy_cnt = 0;
        end else begin
            if (load_valid_i && !pending) begin
                proto_errs++;
                $display("load result pulse with no outstanding load at %0t", $time);
            end else if (!load_valid_i && pending) begin
                proto_errs++;
                $display("no load result pulse one cycle after an accepted load at %0t", $time);
            end else if (load_valid_i && result_i !== expected) begin
                data_errs++;
                $display("** Error [%s] load at 0x%08h: expected 0x%08h, actual 0x%08h",
                         test_name(pending_test), pending_addr, expected, result_i);
            end
            pending = 1'b0;

            if (start_i && hold_i && done_i) begin
                proto_errs++;
                $display("done_o high while hold_i holds a request at %0t", $time);
            end

            if (start_i && !hold_i && done_i) begin
                if (busy_cnt != WAIT) begin
                    proto_errs++;
                    $display("** Error [%s] wait states: expected %0d, actual %0d",
                             test_name(test_id_i), WAIT, busy_cnt);
                end
                busy_cnt = 0;
                if (is_store(req_i.op)) begin
                    shadow[word_index(req_i.addr)] = merge_store(shadow[word_index(req_i.addr)],
                        req_i.op, req_i.addr, req_i.wdata);
                end else begin
                    expected     = ref_load(shadow[word_index(req_i.addr)], req_i.op, req_i.addr);
                    pending      = 1'b1;
                    pending_addr = req_i.addr;
                    pending_test = test_id_i;
                end
            end else if (start_i && !hold_i) begin
                busy_cnt++;   // stalled by the memory.
            end else begin
                busy_cnt = 0;
            end
        end
    end

    assign data_errs_o  = data_errs;
    assign proto_errs_o = proto_errs;

endmodule

// ==== testbench/lsu_asserts.sv ====
// control timing assertions
module lsu_asserts (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             start_i,
    input logic             hold_i,
    input lsu_pkg::mem_op_e op_i,
    input logic             bus_sel_i,
    input logic             done_i,
    input logic             load_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    int   fail_count = 0;
    logic load_accept;

    // accepted load as the core sees it, start with done.
    assign load_accept = start_i && done_i && !is_store(op_i);

    // ********************
    // load result timing
    // ********************

    valid_after_load: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) load_accept |=> load_valid_i
    ) else begin
        fail_count++;
        $error("load_valid_o missing one cycle after an accepted load");
    end

    valid_only_after_load: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) load_valid_i |-> $past(load_accept)
    ) else begin
        fail_count++;
        $error("load_valid_o high without an accepted load one cycle before");
    end

    // ********************
    // strobes
    // ********************

    no_sel_in_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) hold_i |-> !bus_sel_i
    ) else begin
        fail_count++;
        $error("bus select high while hold_i is high");
    end

    done_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !start_i |-> done_i
    ) else begin
        fail_count++;
        $error("done_o low while start_i is low");
    end

endmodule

bind lsu_ctrl lsu_asserts asserts_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .hold_i       (hold_i),
    .op_i         (op_i),
    .bus_sel_i    (bus_sel_o),
    .done_i       (done_o),
    .load_valid_i (load_valid_o)
);

// ==== testbench/lsu_tb.sv ====
// load/store unit testbench
`include "lsu_settings.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int WAIT      = `LSU_WAIT_STATES;
    localparam int DEPTH     = `LSU_MEM_WORDS;
    localparam int REQ_TOTAL = DEPTH + 16 + 26 + 26 + 5 + 10 + 200;
    localparam int TIMEOUT   = REQ_TOTAL * (WAIT + 4) + 500;   // in cycles.

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        hold;
    lsu_req_t    req;
    logic        done;
    logic        load_valid;
    logic [31:0] result;
    int          test_id;
    int          data_errs;
    int          proto_errs;
    int          seed;

    always #10 clk = ~clk;

    lsu_top dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .hold_i       (hold),
        .req_i        (req),
        .done_o       (done),
        .load_valid_o (load_valid),
        .result_o     (result)
    );

    lsu_checker checker_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .hold_i       (hold),
        .req_i        (req),
        .done_i       (done),
        .load_valid_i (load_valid),
        .result_i     (result),
        .test_id_i    (test_id),
        .data_errs_o  (data_errs),
        .proto_errs_o (proto_errs)
    );

    // ********************
    // request driving
    // ********************

    task automatic set_req(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
    endtask

    // presents one request and returns just after the accepting edge.
    task automatic drive_req(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input int hold_cycles);
        int   held;
        logic seen;
        held = 0;
        seen = 1'b0;
        set_req(op, addr, wdata);
        start = 1'b1;
        hold  = (hold_cycles > 0);
        while (!seen) begin
            @(negedge clk);
            seen = done;
            @(posedge clk);
            #2;
            held++;
            if (held >= hold_cycles) hold = 1'b0;
        end
    endtask

    task automatic go_idle();
        start = 1'b0;
        hold  = 1'b0;
        @(posedge clk);
        #2;
    endtask

    // ********************
    // tests
    // ********************

    task automatic fill_memory();
        logic [7:0] b;
        test_id = 0;
        for (int i = 0; i < DEPTH; i++) begin
            b = 8'(i);
            drive_req(MEM_SW, 32'(i * 4), {b ^ 8'ha5, 8'(i * 7), ~b, b}, 0);
        end
        go_idle();
    endtask

    task automatic word_round_trip();
        test_id = 1;
        for (int i = 0; i < 8; i++) begin
            drive_req(MEM_SW, 32'(i * 132) & 32'h3fc, 32'hc0de_0000 | 32'(i * 4099), 0);
        end
        for (int i = 0; i < 8; i++) begin
            drive_req(MEM_LW, (32'(i * 132) & 32'h3fc) | 32'(i % 4), 32'h0, 0);
        end
        go_idle();
    endtask

    task automatic byte_half_merge();
        logic [31:0] base;
        test_id = 2;
        for (int w = 0; w < 2; w++) begin
            base = 32'h40 + 32'(w * 4);
            drive_req(MEM_SW, base, 32'h1122_3344 ^ 32'(w), 0);
            for (int off = 0; off < 4; off++) begin
                drive_req(MEM_SB, base + 32'(off), 32'hdead_be00 | 32'(off * 17), 0);
                drive_req(MEM_LW, base, 32'h0, 0);
            end
            for (int h = 0; h < 2; h++) begin
                drive_req(MEM_SH, base + 32'(h * 3), 32'hfeed_5a00 | 32'(h), 0);   // bit 0 set on h = 1.
                drive_req(MEM_LW, base, 32'h0, 0);
            end
        end
        go_idle();
    endtask

    task automatic sign_extension();
        logic [31:0] base;
        test_id = 3;
        for (int w = 0; w < 2; w++) begin
            base = 32'h180 + 32'(w * 4);
            drive_req(MEM_SW, base, (w == 0) ? 32'h807f_ff01 : 32'h7f80_01ff, 0);
            for (int off = 0; off < 4; off++) begin
                drive_req(MEM_LB, base + 32'(off), 32'h0, 0);
                drive_req(MEM_LBU, base + 32'(off), 32'h0, 0);
            end
            for (int h = 0; h < 2; h++) begin
                drive_req(MEM_LH, base + 32'(h * 2), 32'h0, 0);
                drive_req(MEM_LHU, base + 32'(h * 2 + 1), 32'h0, 0);
            end
        end
        go_idle();
    endtask

    task automatic hold_store();
        test_id = 4;
        drive_req(MEM_SW, 32'h80, 32'h5555_aaaa, 0);
        set_req(MEM_SB, 32'h81, 32'h0000_0077);
        start = 1'b1;
        hold  = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #2;
        end
        go_idle();   // store withdrawn, memory must be untouched.
        drive_req(MEM_LW, 32'h80, 32'h0, 0);
        drive_req(MEM_SB, 32'h81, 32'h0000_0077, 3);
        drive_req(MEM_LW, 32'h80, 32'h0, 0);
        go_idle();
    endtask

    task automatic back_to_back();
        test_id = 5;
        for (int i = 0; i < 10; i++) begin
            if (i % 2 == 0) drive_req(MEM_SW, 32'h200 + 32'(i * 2), 32'h3c3c_0000 | 32'(i), 0);
            else drive_req(MEM_LW, 32'h200 + 32'((i - 1) * 2), 32'h0, 0);
        end
        go_idle();
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        test_id = 6;
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            a = $random(seed);
            d = $random(seed);
            drive_req(mem_op_e'(r[2:0]), a & 32'h3ff, d, (r[5:4] == 2'b00) ? 2 : 0);
        end
        go_idle();
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        seed    = 80;
        rst_n   = 1'b0;
        start   = 1'b0;
        hold    = 1'b0;
        req     = '0;
        test_id = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        fill_memory();
        word_round_trip();
        byte_half_merge();
        sign_extension();
        hold_store();
        back_to_back();
        random_mix();
        repeat (3) @(posedge clk);
        $display("errors: data %0d, protocol %0d, assertion %0d",
                 data_errs, proto_errs, dut_i.ctrl_i.asserts_i.fail_count);
        if (data_errs == 0 && proto_errs == 0 && dut_i.ctrl_i.asserts_i.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== lsu_top.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/store_align.sv
src/load_extract.sv
src/data_ram.sv
src/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_asserts.sv
testbench/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
